// File: logic/lsu_mem_pkg.sv
// lsu memory side types

package lsu_mem_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    // data path width
    localparam int unsigned XLEN = 64;
    // scoreboard tag width, carried with every write-back
    localparam int unsigned TRANS_ID_BITS = 3;

    // ----------------------------------------------------------
    // exceptions
    // ----------------------------------------------------------
    // only the two misaligned causes survive here
    typedef enum logic [XLEN-1:0] {
        EXC_NONE           = 64'd0,
        LD_ADDR_MISALIGNED = 64'd4,
        ST_ADDR_MISALIGNED = 64'd6
    } exc_cause_e;

    typedef struct packed {
        logic             valid;
        exc_cause_e       cause;
        // faulting address
        logic [XLEN-1:0]  tval;
    } lsu_exc_t;

    // ----------------------------------------------------------
    // memory port
    // ----------------------------------------------------------
    typedef struct packed {
        logic             req;
        logic             we;
        logic [XLEN-1:0]  addr;
        logic [7:0]       be;
        logic [XLEN-1:0]  wdata;
    } mem_req_t;

    // gnt is a level, rvalid a pulse one cycle after a granted read
    typedef struct packed {
        logic             gnt;
        logic             rvalid;
        logic [XLEN-1:0]  rdata;
    } mem_rsp_t;

    // ----------------------------------------------------------
    // write-back port
    // ----------------------------------------------------------
    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
        lsu_exc_t                 ex;
    } lsu_wb_t;

endpackage

// File: logic/lsu_op_pkg.sv
// lsu operation types

package lsu_op_pkg;
    import lsu_mem_pkg::*;

    // ----------------------------------------------------------
    // unit select and operations
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        LOAD    = 2'd1,
        STORE   = 2'd2
    } lsu_fu_e;

    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } access_size_e;

    // ----------------------------------------------------------
    // request bundles
    // ----------------------------------------------------------
    // what the issue stage hands over
    typedef struct packed {
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          imm;
        // store data
        logic [XLEN-1:0]          operand_b;
        lsu_fu_e                  fu;
        lsu_op_e                  op;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_issue_t;

    // request as held in the bypass queue
    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          addr;
        logic [XLEN-1:0]          data;
        logic [7:0]               be;
        lsu_fu_e                  fu;
        lsu_op_e                  op;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    // access size of an operation
    function automatic access_size_e size_of_op(lsu_op_e op);
        case (op)
            LB, LBU, SB: return SIZE_B;
            LH, LHU, SH: return SIZE_H;
            LW, LWU, SW: return SIZE_W;
            default:     return SIZE_D;
        endcase
    endfunction

endpackage

// File: logic/result_pipe.sv
// write-back register chain

`timescale 1ns/10ps

module result_pipe import lsu_mem_pkg::*; #(
    parameter int unsigned Depth = 1
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  lsu_wb_t d_i,
    output lsu_wb_t q_o
);

    if (Depth == 0) begin : g_wire
        assign q_o = d_i;
    end else begin : g_regs
        // valid bits reset, payload just follows
        logic [Depth-1:0] vld_q;
        logic [Depth-1:0] exv_q;
        lsu_wb_t          data_q [Depth];

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                vld_q <= '0;
                exv_q <= '0;
            end else begin
                vld_q <= Depth'({vld_q, d_i.valid});
                exv_q <= Depth'({exv_q, d_i.ex.valid});
            end
        end

        always_ff @(posedge clk_i) begin
            data_q[0] <= d_i;
            for (int i = 1; i < Depth; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end

        always_comb begin
            q_o          = data_q[Depth-1];
            q_o.valid    = vld_q[Depth-1];
            q_o.ex.valid = exv_q[Depth-1];
        end
    end

endmodule

// File: logic/lsu_agu.sv
// address generation unit

`timescale 1ns/10ps

module lsu_agu import lsu_mem_pkg::*; import lsu_op_pkg::*; #(
    parameter int unsigned AddrWidth = 39
) (
    input  logic       lsu_valid_i,
    input  lsu_issue_t lsu_issue_i,
    // current queue head, checked for alignment
    input  lsu_ctrl_t  head_i,
    output lsu_ctrl_t  req_o,
    output lsu_exc_t   misaligned_ex_o
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] addr;
    logic [7:0]      be;
    logic            misaligned;

    // ----------------------------------------------------------
    // address and byte enables
    // ----------------------------------------------------------
    // no translation, sum is cut to the physical width
    assign sum  = lsu_issue_i.operand_a + lsu_issue_i.imm;
    assign addr = XLEN'(sum[AddrWidth-1:0]);

    // lanes from low address bits and size
    always_comb begin
        case (size_of_op(lsu_issue_i.op))
            SIZE_B:  be = 8'h01 << addr[2:0];
            SIZE_H:  be = 8'h03 << addr[2:0];
            SIZE_W:  be = 8'h0f << addr[2:0];
            default: be = 8'hff;
        endcase
    end

    always_comb begin
        req_o          = '0;
        req_o.valid    = lsu_valid_i;
        req_o.addr     = addr;
        req_o.data     = lsu_issue_i.operand_b;
        req_o.be       = be;
        req_o.fu       = lsu_issue_i.fu;
        req_o.op       = lsu_issue_i.op;
        req_o.trans_id = lsu_issue_i.trans_id;
    end

    // ----------------------------------------------------------
    // misalignment of the head
    // ----------------------------------------------------------
    always_comb begin
        case (size_of_op(head_i.op))
            SIZE_H:  misaligned = head_i.addr[0];
            SIZE_W:  misaligned = |head_i.addr[1:0];
            SIZE_D:  misaligned = |head_i.addr[2:0];
            // bytes never misalign
            default: misaligned = 1'b0;
        endcase
    end

    // cause picked by unit, address as tval
    always_comb begin
        misaligned_ex_o = '0;
        if (head_i.valid && misaligned) begin
            if (head_i.fu == LOAD) begin
                misaligned_ex_o.valid = 1'b1;
                misaligned_ex_o.cause = LD_ADDR_MISALIGNED;
            end else if (head_i.fu == STORE) begin
                misaligned_ex_o.valid = 1'b1;
                misaligned_ex_o.cause = ST_ADDR_MISALIGNED;
            end
            misaligned_ex_o.tval = head_i.addr;
        end
    end

endmodule

// File: logic/lsu_bypass.sv
// two entry bypass queue

`timescale 1ns/10ps

module lsu_bypass import lsu_mem_pkg::*; import lsu_op_pkg::*; #(
    parameter int unsigned AddrWidth = 39
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  lsu_ctrl_t req_i,
    input  logic      req_valid_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,
    output lsu_ctrl_t ctrl_o,
    output logic      ready_o
);

    lsu_ctrl_t [1:0] mem_d, mem_q;
    logic            rd_ptr_d, rd_ptr_q;
    logic            wr_ptr_d, wr_ptr_q;
    logic [1:0]      cnt_d, cnt_q;
    logic            empty;
    lsu_ctrl_t       stored_head;

    assign empty   = (cnt_q == 2'd0);
    // new work only when nothing waits
    assign ready_o = empty;

    // ----------------------------------------------------------
    // pointer and count update
    // ----------------------------------------------------------
    always_comb begin
        mem_d    = mem_q;
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;
        // write first, a pop in the same cycle may hit this entry
        if (req_valid_i) begin
            mem_d[wr_ptr_q] = req_i;
            wr_ptr_d        = ~wr_ptr_q;
            cnt_d           = cnt_d + 2'd1;
        end
        // only one unit owns the head, so one pop at most
        if (pop_ld_i || pop_st_i) begin
            mem_d[rd_ptr_q].valid = 1'b0;
            rd_ptr_d              = ~rd_ptr_q;
            cnt_d                 = cnt_d - 2'd1;
        end
    end

    // ----------------------------------------------------------
    // head select
    // ----------------------------------------------------------
    // upper address bits are always zero, rebuilt on the way out
    always_comb begin
        stored_head      = mem_q[rd_ptr_q];
        stored_head.addr = XLEN'(mem_q[rd_ptr_q].addr[AddrWidth-1:0]);
    end

    // empty queue hands the incoming request straight through
    assign ctrl_o = empty ? req_i : stored_head;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q    <= '0;
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            mem_q    <= mem_d;
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

endmodule

// File: logic/load_unit.sv
// load unit

`timescale 1ns/10ps

module load_unit import lsu_mem_pkg::*; import lsu_op_pkg::*; #(
    parameter int unsigned AddrWidth = 39
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  lsu_ctrl_t ctrl_i,
    input  lsu_exc_t  ex_i,
    input  mem_rsp_t  mem_rsp_i,
    output mem_req_t  mem_req_o,
    output logic      pop_o,
    output lsu_wb_t   wb_o
);

    // one beat in flight, returned or excepted next cycle
    logic                     pend_q;
    logic [TRANS_ID_BITS-1:0] id_q;
    logic [2:0]               off_q;
    lsu_op_e                  op_q;
    lsu_exc_t                 ex_q;
    logic [XLEN-1:0]          shifted;
    logic [XLEN-1:0]          ext;

    // ----------------------------------------------------------
    // request
    // ----------------------------------------------------------
    // misaligned loads never touch memory
    always_comb begin
        mem_req_o      = '0;
        mem_req_o.req  = ctrl_i.valid && !ex_i.valid;
        mem_req_o.addr = XLEN'(ctrl_i.addr[AddrWidth-1:0]);
        mem_req_o.be   = ctrl_i.be;
    end

    assign pop_o = ctrl_i.valid && (ex_i.valid || mem_rsp_i.gnt);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= pop_o;
        end
    end

    // tag, offset and op for the returning beat
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            id_q  <= ctrl_i.trans_id;
            off_q <= ctrl_i.addr[2:0];
            op_q  <= ctrl_i.op;
            ex_q  <= ex_i;
        end
    end

    // ----------------------------------------------------------
    // align and extend
    // ----------------------------------------------------------
    assign shifted = mem_rsp_i.rdata >> {off_q, 3'b000};

    always_comb begin
        case (op_q)
            LB:      ext = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU:     ext = {{(XLEN-8){1'b0}}, shifted[7:0]};
            LH:      ext = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU:     ext = {{(XLEN-16){1'b0}}, shifted[15:0]};
            LW:      ext = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
            LWU:     ext = {{(XLEN-32){1'b0}}, shifted[31:0]};
            default: ext = shifted;
        endcase
    end

    always_comb begin
        wb_o = '0;
        if (pend_q) begin
            wb_o.valid    = ex_q.valid || mem_rsp_i.rvalid;
            wb_o.trans_id = id_q;
            wb_o.result   = ex_q.valid ? '0 : ext;
            wb_o.ex       = ex_q;
        end
    end

endmodule

// File: logic/store_unit.sv
// store unit

`timescale 1ns/10ps

module store_unit import lsu_mem_pkg::*; import lsu_op_pkg::*; #(
    parameter int unsigned AddrWidth = 39
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  lsu_ctrl_t ctrl_i,
    input  lsu_exc_t  ex_i,
    input  mem_rsp_t  mem_rsp_i,
    output mem_req_t  mem_req_o,
    output logic      pop_o,
    output lsu_wb_t   wb_o
);

    logic                     done_q;
    logic [TRANS_ID_BITS-1:0] id_q;
    lsu_exc_t                 ex_q;

    // data moved into its lanes, writes complete on grant
    always_comb begin
        mem_req_o       = '0;
        mem_req_o.req   = ctrl_i.valid && !ex_i.valid;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = XLEN'(ctrl_i.addr[AddrWidth-1:0]);
        mem_req_o.be    = ctrl_i.be;
        mem_req_o.wdata = ctrl_i.data << {ctrl_i.addr[2:0], 3'b000};
    end

    assign pop_o = ctrl_i.valid && (ex_i.valid || mem_rsp_i.gnt);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_q <= 1'b0;
        end else begin
            done_q <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            id_q <= ctrl_i.trans_id;
            ex_q <= ex_i;
        end
    end

    // completion, result always zero
    always_comb begin
        wb_o = '0;
        if (done_q) begin
            wb_o.valid    = 1'b1;
            wb_o.trans_id = id_q;
            wb_o.ex       = ex_q;
        end
    end

endmodule

// File: logic/load_store_unit.sv
// load store unit top

`timescale 1ns/10ps

module load_store_unit import lsu_mem_pkg::*; import lsu_op_pkg::*; #(
    parameter int unsigned AddrWidth       = 39,
    parameter int unsigned NrLoadPipeRegs  = 1,
    parameter int unsigned NrStorePipeRegs = 0
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    // issue side
    input  logic       lsu_valid_i,
    input  lsu_issue_t lsu_issue_i,
    output logic       lsu_ready_o,
    // memory ports
    output mem_req_t   ld_mem_req_o,
    input  mem_rsp_t   ld_mem_rsp_i,
    output mem_req_t   st_mem_req_o,
    input  mem_rsp_t   st_mem_rsp_i,
    // write-back ports
    output lsu_wb_t    load_wb_o,
    output lsu_wb_t    store_wb_o
);

    lsu_ctrl_t new_req;
    lsu_ctrl_t head;
    lsu_ctrl_t ld_ctrl;
    lsu_ctrl_t st_ctrl;
    lsu_exc_t  misaligned_ex;
    logic      pop_ld;
    logic      pop_st;
    lsu_wb_t   ld_wb;
    lsu_wb_t   st_wb;

    // ----------------------------------------------------------
    // address stage and queue
    // ----------------------------------------------------------
    lsu_agu #(
        .AddrWidth (AddrWidth)
    ) i_agu (
        .lsu_valid_i     (lsu_valid_i),
        .lsu_issue_i     (lsu_issue_i),
        .head_i          (head),
        .req_o           (new_req),
        .misaligned_ex_o (misaligned_ex)
    );

    lsu_bypass #(
        .AddrWidth (AddrWidth)
    ) i_bypass (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (new_req),
        .req_valid_i (lsu_valid_i),
        .pop_ld_i    (pop_ld),
        .pop_st_i    (pop_st),
        .ctrl_o      (head),
        .ready_o     (lsu_ready_o)
    );

    // head goes to exactly one unit, picked by fu
    always_comb begin
        ld_ctrl       = head;
        ld_ctrl.valid = head.valid && (head.fu == LOAD);
        st_ctrl       = head;
        st_ctrl.valid = head.valid && (head.fu == STORE);
    end

    // ----------------------------------------------------------
    // units
    // ----------------------------------------------------------
    load_unit #(
        .AddrWidth (AddrWidth)
    ) i_load_unit (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .ctrl_i    (ld_ctrl),
        .ex_i      (misaligned_ex),
        .mem_rsp_i (ld_mem_rsp_i),
        .mem_req_o (ld_mem_req_o),
        .pop_o     (pop_ld),
        .wb_o      (ld_wb)
    );

    store_unit #(
        .AddrWidth (AddrWidth)
    ) i_store_unit (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .ctrl_i    (st_ctrl),
        .ex_i      (misaligned_ex),
        .mem_rsp_i (st_mem_rsp_i),
        .mem_req_o (st_mem_req_o),
        .pop_o     (pop_st),
        .wb_o      (st_wb)
    );

    // ----------------------------------------------------------
    // output pipes
    // ----------------------------------------------------------
    result_pipe #(
        .Depth (NrLoadPipeRegs)
    ) i_load_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    (ld_wb),
        .q_o    (load_wb_o)
    );

    result_pipe #(
        .Depth (NrStorePipeRegs)
    ) i_store_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    (st_wb),
        .q_o    (store_wb_o)
    );

endmodule

// File: testbench/load_store_unit_props.sv
// lsu interface properties

`timescale 1ns/10ps

module load_store_unit_props import lsu_mem_pkg::*; (
    input logic     clk_i,
    input logic     rst_ni,
    input logic     valid_i,
    input logic     ready_i,
    input mem_req_t ld_req_i,
    input mem_rsp_t ld_rsp_i,
    input mem_req_t st_req_i,
    input mem_rsp_t st_rsp_i,
    input lsu_wb_t  load_wb_i,
    input lsu_wb_t  store_wb_i
);

    // set by the first issue after reset
    logic issued_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            issued_q <= 1'b0;
        end else if (valid_i) begin
            issued_q <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // handshake rules
    // ----------------------------------------------------------
    issue_when_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i |-> ready_i)
        else $error("issue strobe seen while the LSU was not ready");

    // a waiting request may not move
    ld_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld_req_i.req && !ld_rsp_i.gnt |=> ld_req_i.req && $stable(ld_req_i))
        else $error("load memory request changed before its grant");

    st_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        st_req_i.req && !st_rsp_i.gnt |=> st_req_i.req && $stable(st_req_i))
        else $error("store memory request changed before its grant");

    no_early_wb: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !issued_q |-> !load_wb_i.valid && !store_wb_i.valid)
        else $error("write-back valid before any request was issued");

endmodule

bind load_store_unit load_store_unit_props i_props (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (lsu_valid_i),
    .ready_i    (lsu_ready_o),
    .ld_req_i   (ld_mem_req_o),
    .ld_rsp_i   (ld_mem_rsp_i),
    .st_req_i   (st_mem_req_o),
    .st_rsp_i   (st_mem_rsp_i),
    .load_wb_i  (load_wb_o),
    .store_wb_i (store_wb_o)
);

// File: testbench/tb_load_store_unit.sv
// load store unit testbench

`timescale 1ns/10ps

module tb_load_store_unit import lsu_mem_pkg::*; import lsu_op_pkg::*; ();

    localparam int unsigned addr_width     = 39;
    localparam int unsigned num_ops        = 400;
    // worst case per operation, grant stalls included
    localparam int unsigned timeout_cycles = num_ops * 20;

    logic       clk_i        = 1'b0;
    logic       rst_ni       = 1'b0;
    logic       lsu_valid_i  = 1'b0;
    lsu_issue_t lsu_issue_i  = '0;
    mem_rsp_t   ld_mem_rsp_i = '0;
    mem_rsp_t   st_mem_rsp_i = '0;
    logic       lsu_ready_o;
    mem_req_t   ld_mem_req_o;
    mem_req_t   st_mem_req_o;
    lsu_wb_t    load_wb_o;
    lsu_wb_t    store_wb_o;

    int          seed        = 75471;
    int unsigned cycle_count = 0;
    int unsigned check_count = 0;
    int unsigned error_count = 0;
    int unsigned loads_seen  = 0;
    int unsigned stores_seen = 0;

    // 2 KiB shared by both ports, plus the expected image
    logic [XLEN-1:0] mem    [256];
    logic [XLEN-1:0] shadow [256];
    lsu_wb_t         load_exp_q  [$];
    lsu_wb_t         store_exp_q [$];

    load_store_unit #(
        .AddrWidth       (addr_width),
        .NrLoadPipeRegs  (1),
        .NrStorePipeRegs (0)
    ) dut0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lsu_valid_i  (lsu_valid_i),
        .lsu_issue_i  (lsu_issue_i),
        .lsu_ready_o  (lsu_ready_o),
        .ld_mem_req_o (ld_mem_req_o),
        .ld_mem_rsp_i (ld_mem_rsp_i),
        .st_mem_req_o (st_mem_req_o),
        .st_mem_rsp_i (st_mem_rsp_i),
        .load_wb_o    (load_wb_o),
        .store_wb_o   (store_wb_o)
    );

    // ----------------------------------------------------------
    // helpers and reference model
    // ----------------------------------------------------------
    function automatic int unsigned rand_below(int unsigned n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // every doubleword differs, all index bits matter
    function automatic logic [XLEN-1:0] fill_word(int unsigned i);
        return (64'h9e37_79b9_7f4a_7c15 * 64'(i + 1)) ^ {56'd0, 8'(i)};
    endfunction

    function automatic int unsigned op_bytes(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic bit is_load_op(lsu_op_e op);
        return op inside {LB, LBU, LH, LHU, LW, LWU, LD};
    endfunction

    // expected write-back from the ISA rules and the shadow image
    function automatic lsu_wb_t predict_wb(lsu_op_e op, logic [XLEN-1:0] addr,
                                           logic [TRANS_ID_BITS-1:0] id);
        lsu_wb_t         wb;
        int unsigned     n;
        logic [XLEN-1:0] dword;
        logic [XLEN-1:0] val;
        wb          = '0;
        wb.valid    = 1'b1;
        wb.trans_id = id;
        n           = op_bytes(op);
        if (addr % n != 0) begin
            wb.ex.valid = 1'b1;
            wb.ex.tval  = addr;
            if (is_load_op(op)) begin
                wb.ex.cause = LD_ADDR_MISALIGNED;
            end else begin
                wb.ex.cause = ST_ADDR_MISALIGNED;
            end
        end else if (is_load_op(op)) begin
            dword = shadow[addr[10:3]];
            val   = '0;
            for (int unsigned b = 0; b < n; b++) begin
                val[8*b +: 8] = dword[8*(addr[2:0]+b) +: 8];
            end
            // signed forms fill the upper bytes with the top bit
            if ((op inside {LB, LH, LW}) && val[8*n-1]) begin
                for (int unsigned b = n; b < 8; b++) begin
                    val[8*b +: 8] = 8'hff;
                end
            end
            wb.result = val;
        end
        return wb;
    endfunction

    task automatic update_shadow(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                                 input int unsigned n);
        for (int unsigned b = 0; b < n; b++) begin
            shadow[addr[10:3]][8*(addr[2:0]+b) +: 8] = data[8*b +: 8];
        end
    endtask

    task automatic compare_wb(input lsu_wb_t got, input lsu_wb_t exp, input string port);
        check_count++;
        assert (got.trans_id == exp.trans_id) else begin
            error_count++;
            $display("[FAIL] %0t: %s trans_id %0d, expected %0d",
                     $time, port, got.trans_id, exp.trans_id);
        end
        assert (got.result == exp.result) else begin
            error_count++;
            $display("[FAIL] %0t: %s id %0d result %h, expected %h",
                     $time, port, exp.trans_id, got.result, exp.result);
        end
        assert (got.ex == exp.ex) else begin
            error_count++;
            $display("[FAIL] %0t: %s id %0d exception %0b/%0d/%h, expected %0b/%0d/%h",
                     $time, port, exp.trans_id, got.ex.valid, got.ex.cause, got.ex.tval,
                     exp.ex.valid, exp.ex.cause, exp.ex.tval);
        end
    endtask

    task automatic end_run(input bit timed_out);
        $display("summary: %0d checks, %0d errors, %0d load and %0d store write-backs",
                 check_count, error_count, loads_seen, stores_seen);
        if (!timed_out && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // ----------------------------------------------------------
    // clock, reset, watchdog
    // ----------------------------------------------------------
    initial begin : clock_gen
        forever #4 clk_i = ~clk_i;
    end

    initial begin : reset_gen
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
    end

    always @(posedge clk_i) begin : cycle_counter
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        wait (cycle_count >= timeout_cycles);
        $display("timeout: run still busy after %0d cycles", cycle_count);
        end_run(1'b1);
    end

    // ----------------------------------------------------------
    // memory model
    // ----------------------------------------------------------
    // grant high ~70%, read data one cycle after a granted read
    always @(posedge clk_i) begin : memory_model
        ld_mem_rsp_i.gnt <= rand_below(100) < 70;
        st_mem_rsp_i.gnt <= rand_below(100) < 70;
        if (!rst_ni) begin
            ld_mem_rsp_i.rvalid <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(i);
            end
        end else begin
            ld_mem_rsp_i.rvalid <= ld_mem_req_o.req && !ld_mem_req_o.we && ld_mem_rsp_i.gnt;
            ld_mem_rsp_i.rdata  <= mem[ld_mem_req_o.addr[10:3]];
            if (st_mem_req_o.req && st_mem_req_o.we && st_mem_rsp_i.gnt) begin
                for (int b = 0; b < 8; b++) begin
                    if (st_mem_req_o.be[b]) begin
                        mem[st_mem_req_o.addr[10:3]][8*b +: 8] <= st_mem_req_o.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    initial begin : stimulus
        lsu_issue_t      issue;
        logic [XLEN-1:0] sum;
        logic [XLEN-1:0] addr;
        int unsigned     n;
        bit              misalign;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(i);
        end
        @(posedge clk_i);
        while (!rst_ni) begin
            @(posedge clk_i);
        end
        for (int k = 0; k < num_ops; k++) begin
            while (!lsu_ready_o) begin
                @(posedge clk_i);
            end
            issue           = '0;
            issue.op        = lsu_op_e'(rand_below(11));
            issue.trans_id  = TRANS_ID_BITS'(k);
            // random upper bits exercise the cut to the physical width
            issue.operand_a = {$random(seed), $random(seed)};
            issue.operand_a[10:8] = 3'b000;
            issue.operand_b = {$random(seed), $random(seed)};
            issue.imm       = 64'(rand_below(256)) - 64'd128;
            if (is_load_op(issue.op)) begin
                issue.fu = LOAD;
            end else begin
                issue.fu = STORE;
            end
            n        = op_bytes(issue.op);
            misalign = (n > 1) && (rand_below(10) == 0);
            sum      = issue.operand_a + issue.imm;
            if (!misalign) begin
                issue.imm = issue.imm - (sum % n);
            end else if (sum % n == 0) begin
                issue.imm = issue.imm + 64'd1;
            end
            addr = (issue.operand_a + issue.imm) & ((64'd1 << addr_width) - 64'd1);
            if (issue.fu == LOAD) begin
                load_exp_q.push_back(predict_wb(issue.op, addr, issue.trans_id));
            end else begin
                store_exp_q.push_back(predict_wb(issue.op, addr, issue.trans_id));
                if (addr % n == 0) begin
                    update_shadow(addr, issue.operand_b, n);
                end
            end
            lsu_valid_i <= 1'b1;
            lsu_issue_i <= issue;
            @(posedge clk_i);
            lsu_valid_i <= 1'b0;
            @(posedge clk_i);
        end
        while (load_exp_q.size() != 0 || store_exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        // a few idle cycles to catch duplicate write-backs
        repeat (8) @(posedge clk_i);
        assert (loads_seen + stores_seen == num_ops) else begin
            error_count++;
            $display("[FAIL] %0t: %0d write-backs for %0d issued operations",
                     $time, loads_seen + stores_seen, num_ops);
        end
        end_run(1'b0);
    end

    // ----------------------------------------------------------
    // compare
    // ----------------------------------------------------------
    always @(posedge clk_i) begin : compare_proc
        lsu_wb_t exp;
        if (rst_ni && load_wb_o.valid) begin
            loads_seen++;
            assert (load_exp_q.size() != 0) else begin
                error_count++;
                $display("load write-back id %0d arrived with no load outstanding",
                         load_wb_o.trans_id);
            end
            if (load_exp_q.size() != 0) begin
                exp = load_exp_q.pop_front();
                compare_wb(load_wb_o, exp, "load");
            end
        end
        if (rst_ni && store_wb_o.valid) begin
            stores_seen++;
            assert (store_exp_q.size() != 0) else begin
                error_count++;
                $display("store write-back id %0d arrived with no store outstanding",
                         store_wb_o.trans_id);
            end
            if (store_exp_q.size() != 0) begin
                exp = store_exp_q.pop_front();
                compare_wb(store_wb_o, exp, "store");
            end
        end
    end

endmodule

// File: load_store_unit.f
logic/lsu_mem_pkg.sv
logic/lsu_op_pkg.sv
logic/result_pipe.sv
logic/lsu_agu.sv
logic/lsu_bypass.sv
logic/load_unit.sv
logic/store_unit.sv
logic/load_store_unit.sv
testbench/load_store_unit_props.sv
testbench/tb_load_store_unit.sv

// File: Makefile
# Verilator build and run for the load store unit

VERILATOR  := verilator
TOP        := tb_load_store_unit
FILELIST   := load_store_unit.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the outcome, not the exit code of the binary
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "pass line missing in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
